//--- verilog/icache_pkg.sv
/*
    Shared constants and types for the 2-way instruction cache.
    Block size, fetch width and L2 address width are fixed by the L2 side
    and are not meant to change per instance. Only the set count varies.
    Tag width depends on the set count, so each module derives it locally
    as L2_ADDR_WIDTH minus the index width.
*/
package icache_pkg;

    // --------------------
    // L2 geometry

    // block address, {tag, index}, byte offset already dropped
    localparam int L2_ADDR_WIDTH = 29;

    localparam int BLOCK_BYTES = 32;
    localparam int FETCH_BYTES = 16;

    // two half-block fetches per block
    localparam int FETCHES_PER_BLOCK = BLOCK_BYTES / FETCH_BYTES;

    // used when the top level is not overridden
    localparam int DEFAULT_NUM_SETS = 128;

    // --------------------
    // fixed-width types

    typedef logic [L2_ADDR_WIDTH-1:0] block_addr_t;

    typedef logic [BLOCK_BYTES*8-1:0] block_data_t;

    typedef logic [FETCH_BYTES*8-1:0] fetch_data_t;

    // selects low or high half of a block
    typedef logic [$clog2(FETCHES_PER_BLOCK)-1:0] fetch_sel_t;

    // --------------------
    // miss unit FSM

    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        REQUEST   = 3'd1,
        WAIT_RESP = 3'd2,
        FILL_LOW  = 3'd3,
        FILL_HIGH = 3'd4
    } miss_state_e;

endpackage

//--- verilog/icache_fill_if.sv
/*
    Array write bus from the miss unit to the tag store and data array.
    No handshake: each cycle with write_valid high is exactly one write.
    tag and tag_valid belong to the way being filled; other_valid and
    other_tag carry the untouched way so a full set entry can be written.
*/
interface icache_fill_if #(
    parameter int NUM_SETS = icache_pkg::DEFAULT_NUM_SETS
);
    localparam int INDEX_WIDTH = $clog2(NUM_SETS);
    localparam int TAG_WIDTH = icache_pkg::L2_ADDR_WIDTH - INDEX_WIDTH;

    logic                   write_valid;
    logic [INDEX_WIDTH-1:0] index;
    icache_pkg::fetch_sel_t fetch_sel;
    logic                   way;
    logic [TAG_WIDTH-1:0]   tag;
    logic                   tag_valid;
    logic                   other_valid;
    logic [TAG_WIDTH-1:0]   other_tag;
    icache_pkg::fetch_data_t data;

    modport source (
        output write_valid, index, fetch_sel, way, tag, tag_valid,
        output other_valid, other_tag, data
    );

    modport sink (
        input write_valid, index, fetch_sel, way, tag, tag_valid,
        input other_valid, other_tag, data
    );

endinterface

//--- verilog/bram_1r1w.sv
/*
    Synchronous RAM, one read port and one write port.
    WIDTH must be a multiple of 8, write enables are per byte.
    Read data is registered, so a read takes one cycle.
    Read and write to the same entry in one cycle returns the old data.
    Contents are cleared on reset, so keep DEPTH modest.
*/
module bram_1r1w #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 64,
    localparam int BYTES = WIDTH / 8,
    localparam int INDEX_WIDTH = $clog2(DEPTH)
) (
    input  logic                   CLK,
    input  logic                   nRST,

    input  logic                   read_en,
    input  logic [INDEX_WIDTH-1:0] read_index,
    output logic [WIDTH-1:0]       read_data,

    input  logic [BYTES-1:0]       write_byte_en,
    input  logic [INDEX_WIDTH-1:0] write_index,
    input  logic [WIDTH-1:0]       write_data
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            mem <= '{default: '0};
            read_data <= '0;
        end else begin
            // old contents seen on a same-cycle collision
            if (read_en) begin
                read_data <= mem[read_index];
            end
            for (int b = 0; b < BYTES; b++) begin
                if (write_byte_en[b]) begin
                    mem[write_index][b*8 +: 8] <= write_data[b*8 +: 8];
                end
            end
        end
    end

    // an X enable would corrupt an unknown set of bytes
    a_write_en_known: assert property (
        @(posedge CLK) disable iff (!nRST)
        !$isunknown(write_byte_en)
    ) else $error("bram write enable unknown");

endmodule

//--- verilog/icache_tag_store.sv
/*
    Valid bits and tags for both ways of every set, plus the LRU bits.
    Tag read takes one cycle; lru_way is combinational on resp_index.
    A hit makes the other way LRU. The last fill write makes the filled
    way MRU. On the same set in one cycle the hit wins.
    After reset all entries are invalid and every LRU bit selects way 0.
*/
module icache_tag_store #(
    parameter int NUM_SETS = icache_pkg::DEFAULT_NUM_SETS,
    localparam int INDEX_WIDTH = $clog2(NUM_SETS),
    localparam int TAG_WIDTH = icache_pkg::L2_ADDR_WIDTH - INDEX_WIDTH
) (
    input  logic                       CLK,
    input  logic                       nRST,

    input  logic                       read_valid,
    input  logic [INDEX_WIDTH-1:0]     read_index,
    input  logic [INDEX_WIDTH-1:0]     resp_index,

    input  logic                       hit_valid,
    input  logic                       hit_way,

    icache_fill_if.sink                fill,

    output logic [1:0]                 valid_by_way,
    output logic [1:0][TAG_WIDTH-1:0]  tag_by_way,
    output logic                       lru_way
);

    typedef struct packed {
        logic [1:0]                valid_by_way;
        logic [1:0][TAG_WIDTH-1:0] tag_by_way;
    } tag_entry_t;

    localparam int ENTRY_WIDTH = $bits(tag_entry_t);
    // round up to whole bytes for the RAM
    localparam int RAM_WIDTH = ((ENTRY_WIDTH + 7) / 8) * 8;

    tag_entry_t             read_entry;
    tag_entry_t             write_entry;
    logic [RAM_WIDTH-1:0]   read_raw;
    logic [RAM_WIDTH-1:0]   write_raw;
    logic [NUM_SETS-1:0]    lru_array;
    logic                   fill_done;

    // --------------------
    // tag array

    // rebuild the whole set, filled way plus the surviving way
    always_comb begin
        if (fill.way) begin
            write_entry.valid_by_way = {fill.tag_valid, fill.other_valid};
            write_entry.tag_by_way = {fill.tag, fill.other_tag};
        end else begin
            write_entry.valid_by_way = {fill.other_valid, fill.tag_valid};
            write_entry.tag_by_way = {fill.other_tag, fill.tag};
        end
    end

    assign write_raw = RAM_WIDTH'(write_entry);
    assign read_entry = read_raw[ENTRY_WIDTH-1:0];

    bram_1r1w #(
        .WIDTH(RAM_WIDTH),
        .DEPTH(NUM_SETS)
    ) tag_ram (
        .CLK(CLK),
        .nRST(nRST),
        .read_en(read_valid),
        .read_index(read_index),
        .read_data(read_raw),
        .write_byte_en({(RAM_WIDTH / 8){fill.write_valid}}),
        .write_index(fill.index),
        .write_data(write_raw)
    );

    assign valid_by_way = read_entry.valid_by_way;
    assign tag_by_way = read_entry.tag_by_way;

    // --------------------
    // LRU bits

    // second half write marks the end of a fill
    assign fill_done = fill.write_valid & fill.tag_valid;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            lru_array <= '0;
        end else begin
            if (fill_done) begin
                lru_array[fill.index] <= ~fill.way;
            end
            // later assignment, so a hit overrides the fill
            if (hit_valid) begin
                lru_array[resp_index] <= ~hit_way;
            end
        end
    end

    assign lru_way = lru_array[resp_index];

    a_fill_hit_lru: assert property (
        @(posedge CLK) disable iff (!nRST)
        (fill_done && hit_valid && (fill.index == resp_index)) |-> (hit_way == fill.way)
    ) else $error("hit and fill disagree on the LRU way of one set");

endmodule

//--- verilog/icache_miss_unit.sv
/*
    Single miss register with L2 request and fill sequencing.
    A miss is taken only in IDLE; a miss while busy is dropped and the
    core has to retry. l2_req_valid rises the cycle after acceptance and
    holds until l2_req_ready. Only a response whose address matches the
    request ends the wait. The block is then written as two halves,
    tag invalid with the low half and valid with the high half.
*/
module icache_miss_unit #(
    parameter int NUM_SETS = icache_pkg::DEFAULT_NUM_SETS,
    localparam int INDEX_WIDTH = $clog2(NUM_SETS),
    localparam int TAG_WIDTH = icache_pkg::L2_ADDR_WIDTH - INDEX_WIDTH
) (
    input  logic                     CLK,
    input  logic                     nRST,

    // miss from core feedback
    input  logic                     miss_valid,
    input  logic [INDEX_WIDTH-1:0]   miss_index,
    input  logic [TAG_WIDTH-1:0]     miss_tag,
    input  logic                     victim_way,
    input  logic                     other_valid,
    input  logic [TAG_WIDTH-1:0]     other_tag,

    // L2 request
    output logic                     l2_req_valid,
    output icache_pkg::block_addr_t  l2_req_addr,
    input  logic                     l2_req_ready,

    // L2 response
    input  logic                     l2_resp_valid,
    input  icache_pkg::block_addr_t  l2_resp_addr,
    input  icache_pkg::block_data_t  l2_resp_data,

    icache_fill_if.source            fill
);

    icache_pkg::miss_state_e state_q;
    icache_pkg::miss_state_e state_d;

    logic                     accept;
    logic                     resp_match;
    icache_pkg::fetch_sel_t   fill_sel;

    // miss register payload
    logic [INDEX_WIDTH-1:0]   index_q;
    logic [TAG_WIDTH-1:0]     tag_q;
    logic                     victim_q;
    logic                     other_valid_q;
    logic [TAG_WIDTH-1:0]     other_tag_q;
    icache_pkg::fetch_data_t [icache_pkg::FETCHES_PER_BLOCK-1:0] block_q;

    // --------------------
    // FSM

    assign accept = (state_q == icache_pkg::IDLE) && miss_valid;
    assign resp_match = (state_q == icache_pkg::WAIT_RESP) && l2_resp_valid
                        && (l2_resp_addr == l2_req_addr);

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            icache_pkg::IDLE: begin
                if (miss_valid) begin
                    state_d = icache_pkg::REQUEST;
                end
            end
            icache_pkg::REQUEST: begin
                if (l2_req_ready) begin
                    state_d = icache_pkg::WAIT_RESP;
                end
            end
            icache_pkg::WAIT_RESP: begin
                // other addresses are ignored
                if (resp_match) begin
                    state_d = icache_pkg::FILL_LOW;
                end
            end
            icache_pkg::FILL_LOW: state_d = icache_pkg::FILL_HIGH;
            icache_pkg::FILL_HIGH: state_d = icache_pkg::IDLE;
            default: state_d = icache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state_q <= icache_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // payload, only meaningful outside IDLE
    always_ff @(posedge CLK) begin
        if (accept) begin
            index_q <= miss_index;
            tag_q <= miss_tag;
            victim_q <= victim_way;
            other_valid_q <= other_valid;
            other_tag_q <= other_tag;
        end
        if (resp_match) begin
            block_q <= l2_resp_data;
        end
    end

    // --------------------
    // outputs

    assign l2_req_valid = (state_q == icache_pkg::REQUEST);
    assign l2_req_addr = {tag_q, index_q};

    assign fill_sel = icache_pkg::fetch_sel_t'(state_q == icache_pkg::FILL_HIGH);

    assign fill.write_valid = (state_q == icache_pkg::FILL_LOW)
                              || (state_q == icache_pkg::FILL_HIGH);
    assign fill.index = index_q;
    assign fill.fetch_sel = fill_sel;
    assign fill.way = victim_q;
    assign fill.tag = tag_q;
    // way becomes valid only once both halves are in
    assign fill.tag_valid = (state_q == icache_pkg::FILL_HIGH);
    assign fill.other_valid = other_valid_q;
    assign fill.other_tag = other_tag_q;
    assign fill.data = block_q[fill_sel];

    a_l2_req_hold: assert property (
        @(posedge CLK) disable iff (!nRST)
        (l2_req_valid && !l2_req_ready) |=> (l2_req_valid && $stable(l2_req_addr))
    ) else $error("L2 request dropped or changed before ready");

endmodule

//--- verilog/icache.sv
/*
    Blocking 2-way set-associative instruction cache, 32B blocks, 16B fetch.
    Response comes one cycle after core_req_valid and is valid only then.
    The core compares tags itself and gives hit or miss feedback in that
    same cycle; feedback applies to the index of that response.
    A miss while the miss unit is busy is ignored and must be retried.
    No snoop invalidation and no bypass of returning miss data.
*/
module icache #(
    parameter int NUM_SETS = icache_pkg::DEFAULT_NUM_SETS,
    localparam int INDEX_WIDTH = $clog2(NUM_SETS),
    localparam int TAG_WIDTH = icache_pkg::L2_ADDR_WIDTH - INDEX_WIDTH
) (
    input  logic                              CLK,
    input  logic                              nRST,

    // core request
    input  logic                              core_req_valid,
    input  logic [INDEX_WIDTH-1:0]            core_req_index,
    input  icache_pkg::fetch_sel_t            core_req_fetch_sel,

    // core response
    output logic [1:0]                        core_resp_valid_by_way,
    output logic [1:0][TAG_WIDTH-1:0]         core_resp_tag_by_way,
    output icache_pkg::fetch_data_t [1:0]     core_resp_data_by_way,

    // core feedback
    input  logic                              core_hit_valid,
    input  logic                              core_hit_way,
    input  logic                              core_miss_valid,
    input  logic [TAG_WIDTH-1:0]              core_miss_tag,

    // L2 request
    output logic                              l2_req_valid,
    output icache_pkg::block_addr_t           l2_req_addr,
    input  logic                              l2_req_ready,

    // L2 response
    input  logic                              l2_resp_valid,
    input  icache_pkg::block_addr_t           l2_resp_addr,
    input  icache_pkg::block_data_t           l2_resp_data
);

    localparam int DATA_DEPTH = NUM_SETS * icache_pkg::FETCHES_PER_BLOCK;

    logic [INDEX_WIDTH-1:0]                   resp_index;
    logic                                     lru_way;
    logic                                     other_way;
    logic                                     other_valid;
    logic [TAG_WIDTH-1:0]                     other_tag;
    logic [1:0][icache_pkg::FETCH_BYTES-1:0]  data_write_byte_en;

    icache_fill_if #(.NUM_SETS(NUM_SETS)) fill_bus ();

    // feedback in the response cycle refers to this index
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            resp_index <= '0;
        end else if (core_req_valid) begin
            resp_index <= core_req_index;
        end
    end

    // the LRU way is replaced, the other way survives the fill
    assign other_way = ~lru_way;
    assign other_valid = core_resp_valid_by_way[other_way];
    assign other_tag = core_resp_tag_by_way[other_way];

    // --------------------
    // arrays

    icache_tag_store #(
        .NUM_SETS(NUM_SETS)
    ) tag_store_i (
        .CLK(CLK),
        .nRST(nRST),
        .read_valid(core_req_valid),
        .read_index(core_req_index),
        .resp_index(resp_index),
        .hit_valid(core_hit_valid),
        .hit_way(core_hit_way),
        .fill(fill_bus.sink),
        .valid_by_way(core_resp_valid_by_way),
        .tag_by_way(core_resp_tag_by_way),
        .lru_way(lru_way)
    );

    // both ways share one row, the byte mask picks the way
    always_comb begin
        data_write_byte_en = '0;
        if (fill_bus.write_valid) begin
            data_write_byte_en[fill_bus.way] = '1;
        end
    end

    bram_1r1w #(
        .WIDTH(2 * icache_pkg::FETCH_BYTES * 8),
        .DEPTH(DATA_DEPTH)
    ) data_ram (
        .CLK(CLK),
        .nRST(nRST),
        .read_en(core_req_valid),
        .read_index({core_req_index, core_req_fetch_sel}),
        .read_data(core_resp_data_by_way),
        .write_byte_en(data_write_byte_en),
        .write_index({fill_bus.index, fill_bus.fetch_sel}),
        .write_data({fill_bus.data, fill_bus.data})
    );

    // --------------------
    // miss handling

    icache_miss_unit #(
        .NUM_SETS(NUM_SETS)
    ) miss_unit_i (
        .CLK(CLK),
        .nRST(nRST),
        .miss_valid(core_miss_valid),
        .miss_index(resp_index),
        .miss_tag(core_miss_tag),
        .victim_way(lru_way),
        .other_valid(other_valid),
        .other_tag(other_tag),
        .l2_req_valid(l2_req_valid),
        .l2_req_addr(l2_req_addr),
        .l2_req_ready(l2_req_ready),
        .l2_resp_valid(l2_resp_valid),
        .l2_resp_addr(l2_resp_addr),
        .l2_resp_data(l2_resp_data),
        .fill(fill_bus.source)
    );

endmodule

//--- testbench/icache_tb.sv
/*
    Testbench for the 2-way instruction cache, built with 8 sets.
    A small L2 model drops ready at random and answers after a random
    delay. Expected contents come from a model of valid bits, tags and
    LRU bits kept here, with block data from l2_block.
    Core feedback is always given in the response cycle.
*/
module icache_tb;

    localparam int NUM_SETS = 8;
    localparam int INDEX_WIDTH = $clog2(NUM_SETS);
    localparam int TAG_WIDTH = icache_pkg::L2_ADDR_WIDTH - INDEX_WIDTH;
    localparam int PERIOD = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int SAMPLE_DELAY = 10;
    localparam int NUM_TESTS = 5;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 200 + 100;

    localparam logic [INDEX_WIDTH-1:0] SET_FILL = INDEX_WIDTH'(3);
    localparam logic [INDEX_WIDTH-1:0] SET_BUSY = INDEX_WIDTH'(5);
    localparam logic [INDEX_WIDTH-1:0] SET_PROBE = INDEX_WIDTH'(6);

    localparam logic [TAG_WIDTH-1:0] TAG_A = TAG_WIDTH'(32'h0001_2345);
    localparam logic [TAG_WIDTH-1:0] TAG_B = TAG_WIDTH'(32'h0020_0abc);
    localparam logic [TAG_WIDTH-1:0] TAG_C = TAG_WIDTH'(32'h0155_5555);
    localparam logic [TAG_WIDTH-1:0] TAG_D = TAG_WIDTH'(32'h02aa_aaaa);
    localparam logic [TAG_WIDTH-1:0] TAG_E = TAG_WIDTH'(32'h00c0_ffee);

    logic                              CLK = 1'b0;
    logic                              nRST;

    logic                              core_req_valid;
    logic [INDEX_WIDTH-1:0]            core_req_index;
    icache_pkg::fetch_sel_t            core_req_fetch_sel;
    logic [1:0]                        core_resp_valid_by_way;
    logic [1:0][TAG_WIDTH-1:0]         core_resp_tag_by_way;
    icache_pkg::fetch_data_t [1:0]     core_resp_data_by_way;
    logic                              core_hit_valid;
    logic                              core_hit_way;
    logic                              core_miss_valid;
    logic [TAG_WIDTH-1:0]              core_miss_tag;

    logic                              l2_req_valid;
    icache_pkg::block_addr_t           l2_req_addr;
    logic                              l2_req_ready;
    logic                              l2_resp_valid;
    icache_pkg::block_addr_t           l2_resp_addr;
    icache_pkg::block_data_t           l2_resp_data;

    // reference model of the tag store
    logic [1:0]                        model_valid [NUM_SETS];
    logic [TAG_WIDTH-1:0]              model_tag [NUM_SETS][2];
    logic                              model_lru [NUM_SETS];

    icache_pkg::block_addr_t           expected_l2_addr;
    logic                              wrong_resp_first;
    int                                l2_req_count = 0;
    int                                l2_resp_count = 0;
    int                                expected_req_count = 0;
    int                                check_count = 0;
    int                                value_errors = 0;
    int                                protocol_errors = 0;
    integer                            seed = 5328;

    always #(PERIOD / 2) CLK = ~CLK;

    icache #(
        .NUM_SETS(NUM_SETS)
    ) icache_i (
        .CLK(CLK),
        .nRST(nRST),
        .core_req_valid(core_req_valid),
        .core_req_index(core_req_index),
        .core_req_fetch_sel(core_req_fetch_sel),
        .core_resp_valid_by_way(core_resp_valid_by_way),
        .core_resp_tag_by_way(core_resp_tag_by_way),
        .core_resp_data_by_way(core_resp_data_by_way),
        .core_hit_valid(core_hit_valid),
        .core_hit_way(core_hit_way),
        .core_miss_valid(core_miss_valid),
        .core_miss_tag(core_miss_tag),
        .l2_req_valid(l2_req_valid),
        .l2_req_addr(l2_req_addr),
        .l2_req_ready(l2_req_ready),
        .l2_resp_valid(l2_resp_valid),
        .l2_resp_addr(l2_resp_addr),
        .l2_resp_data(l2_resp_data)
    );

    // --------------------
    // reference and compare tasks

    // every 32-bit word is {block address, word number}
    function automatic icache_pkg::block_data_t l2_block(input icache_pkg::block_addr_t addr);
        icache_pkg::block_data_t blk;
        for (int w = 0; w < icache_pkg::BLOCK_BYTES / 4; w++) begin
            blk[w*32 +: 32] = {addr, 3'(w)};
        end
        return blk;
    endfunction

    task automatic check_valid(input logic [1:0] actual, input logic [1:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            value_errors++;
            $display("[ERROR] %0t: %s valid bits %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic check_tag(input logic [TAG_WIDTH-1:0] actual,
                             input logic [TAG_WIDTH-1:0] expected, input string what);
        check_count++;
        if (actual !== expected) begin
            value_errors++;
            $display("[ERROR] %0t: %s tag %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_data(input icache_pkg::fetch_data_t actual,
                              input icache_pkg::fetch_data_t expected, input string what);
        check_count++;
        if (actual !== expected) begin
            value_errors++;
            $display("[ERROR] %0t: %s data %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_l2_addr(input icache_pkg::block_addr_t actual,
                                 input icache_pkg::block_addr_t expected, input string what);
        check_count++;
        if (actual !== expected) begin
            value_errors++;
            $display("[ERROR] %0t: %s %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic compare_response(input logic [INDEX_WIDTH-1:0] idx,
                                    input icache_pkg::fetch_sel_t sel);
        icache_pkg::fetch_data_t [1:0] halves;
        check_valid(core_resp_valid_by_way, model_valid[idx], $sformatf("set %0d", idx));
        for (int w = 0; w < 2; w++) begin
            if (model_valid[idx][w]) begin
                halves = l2_block({model_tag[idx][w], idx});
                check_tag(core_resp_tag_by_way[w], model_tag[idx][w],
                          $sformatf("set %0d way %0d", idx, w));
                check_data(core_resp_data_by_way[w], halves[sel],
                           $sformatf("set %0d way %0d half %0d", idx, w, sel));
            end
        end
    endtask

    // response checked mid-cycle, one cycle after each request
    always @(posedge CLK) begin : response_compare
        logic [INDEX_WIDTH-1:0] idx;
        icache_pkg::fetch_sel_t sel;
        if (nRST === 1'b1 && core_req_valid === 1'b1) begin
            idx = core_req_index;
            sel = core_req_fetch_sel;
            #(SAMPLE_DELAY);
            compare_response(idx, sel);
        end
    end

    // --------------------
    // L2 model

    task automatic send_response(input icache_pkg::block_addr_t addr);
        int delay;
        delay = 1 + ($random(seed) & 3);
        repeat (delay) @(posedge CLK);
        #(DRIVE_DELAY);
        l2_resp_valid = 1'b1;
        l2_resp_addr = addr;
        l2_resp_data = l2_block(addr);
        @(posedge CLK);
        #(DRIVE_DELAY);
        l2_resp_valid = 1'b0;
    endtask

    initial begin : l2_model
        icache_pkg::block_addr_t addr;
        logic holding;
        l2_req_ready = 1'b0;
        l2_resp_valid = 1'b0;
        l2_resp_addr = '0;
        l2_resp_data = '0;
        holding = 1'b0;
        forever begin
            @(posedge CLK);
            // a stalled request must hold
            if (holding) begin
                if (l2_req_valid !== 1'b1) begin
                    protocol_errors++;
                    $display("L2 request was withdrawn before ready at time %0t", $time);
                end
                check_l2_addr(l2_req_addr, expected_l2_addr, "stalled L2 request address");
            end
            holding = (l2_req_valid === 1'b1) && (l2_req_ready !== 1'b1);
            if (l2_req_valid === 1'b1 && l2_req_ready === 1'b1) begin
                addr = l2_req_addr;
                l2_req_count++;
                check_l2_addr(addr, expected_l2_addr, "L2 request address");
                #(DRIVE_DELAY);
                l2_req_ready = 1'b0;
                if (wrong_resp_first) begin
                    // flip the low tag bit, same set
                    send_response(addr ^ (icache_pkg::block_addr_t'(1) << INDEX_WIDTH));
                end
                send_response(addr);
                l2_resp_count++;
            end else begin
                #(DRIVE_DELAY);
                l2_req_ready = ($random(seed) & 1) != 0;
            end
        end
    end

    // --------------------
    // core side tasks, all entered and left 2 units after an edge

    task automatic issue_request(input logic [INDEX_WIDTH-1:0] idx,
                                 input icache_pkg::fetch_sel_t sel);
        core_req_valid = 1'b1;
        core_req_index = idx;
        core_req_fetch_sel = sel;
        @(posedge CLK);
        #(DRIVE_DELAY);
        core_req_valid = 1'b0;
    endtask

    task automatic give_hit(input logic [INDEX_WIDTH-1:0] idx, input logic way);
        core_hit_valid = 1'b1;
        core_hit_way = way;
        @(posedge CLK);
        #(DRIVE_DELAY);
        core_hit_valid = 1'b0;
        model_lru[idx] = ~way;
    endtask

    task automatic give_miss(input logic [TAG_WIDTH-1:0] tag);
        core_miss_valid = 1'b1;
        core_miss_tag = tag;
        @(posedge CLK);
        #(DRIVE_DELAY);
        core_miss_valid = 1'b0;
    endtask

    task automatic start_miss(input logic [INDEX_WIDTH-1:0] idx,
                              input logic [TAG_WIDTH-1:0] tag,
                              output int target, output logic victim);
        issue_request(idx, 1'b0);
        victim = model_lru[idx];
        expected_l2_addr = {tag, idx};
        expected_req_count++;
        target = l2_resp_count + 1;
        give_miss(tag);
    endtask

    task automatic finish_fill(input logic [INDEX_WIDTH-1:0] idx,
                               input logic [TAG_WIDTH-1:0] tag,
                               input logic victim, input int target);
        wait (l2_resp_count == target);
        // low half, high half, then back in IDLE
        repeat (2) @(posedge CLK);
        #(DRIVE_DELAY);
        model_valid[idx][victim] = 1'b1;
        model_tag[idx][victim] = tag;
        model_lru[idx] = ~victim;
    endtask

    task automatic miss_and_fill(input logic [INDEX_WIDTH-1:0] idx,
                                 input logic [TAG_WIDTH-1:0] tag);
        int target;
        logic victim;
        start_miss(idx, tag, target, victim);
        finish_fill(idx, tag, victim, target);
        issue_request(idx, 1'b0);
        issue_request(idx, 1'b1);
    endtask

    // --------------------
    // test sequence

    initial begin : stimulus
        int target;
        logic victim;
        nRST = 1'b0;
        core_req_valid = 1'b0;
        core_req_index = '0;
        core_req_fetch_sel = '0;
        core_hit_valid = 1'b0;
        core_hit_way = 1'b0;
        core_miss_valid = 1'b0;
        core_miss_tag = '0;
        wrong_resp_first = 1'b0;
        expected_l2_addr = '0;
        for (int s = 0; s < NUM_SETS; s++) begin
            model_valid[s] = 2'b00;
            model_tag[s][0] = '0;
            model_tag[s][1] = '0;
            model_lru[s] = 1'b0;
        end
        repeat (8) @(posedge CLK);
        #(DRIVE_DELAY);
        nRST = 1'b1;
        @(posedge CLK);
        #(DRIVE_DELAY);

        // every set empty after reset
        for (int s = 0; s < NUM_SETS; s++) begin
            issue_request(INDEX_WIDTH'(s), 1'b0);
        end

        // first fill lands in way 0, second in way 1
        miss_and_fill(SET_FILL, TAG_A);
        miss_and_fill(SET_FILL, TAG_B);

        // hit on A leaves B as LRU, so C replaces B
        issue_request(SET_FILL, 1'b0);
        give_hit(SET_FILL, 1'b0);
        miss_and_fill(SET_FILL, TAG_C);

        // wrong L2 address first, plus a second miss while busy
        wrong_resp_first = 1'b1;
        start_miss(SET_BUSY, TAG_D, target, victim);
        issue_request(SET_PROBE, 1'b1);
        give_miss(TAG_E);
        finish_fill(SET_BUSY, TAG_D, victim, target);
        wrong_resp_first = 1'b0;
        issue_request(SET_BUSY, 1'b0);
        issue_request(SET_BUSY, 1'b1);
        issue_request(SET_PROBE, 1'b0);

        repeat (4) @(posedge CLK);
        if (l2_req_count != expected_req_count) begin
            value_errors++;
            $display("[ERROR] %0t: %0d L2 requests seen, expected %0d",
                     $time, l2_req_count, expected_req_count);
        end
        $display("checks: %0d, value errors: %0d, protocol errors: %0d",
                 check_count, value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- compile.f
verilog/icache_pkg.sv
verilog/icache_fill_if.sv
verilog/bram_1r1w.sv
verilog/icache_tag_store.sv
verilog/icache_miss_unit.sv
verilog/icache.sv
testbench/icache_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = icache_tb
FILELIST = compile.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
